// File: design/board_ctrl.sv
// board control keys
// gathers coin and start from every player, runs the pause toggle,
// the service key, the graphics layer enables and the soft reset

module board_ctrl (
    input  logic                                  clk_sys,
    input  logic                                  rst,
    input  logic                                  downloading,
    input  board_pkg::board_joy_t                 joy_sync [board_pkg::NUM_PLAYERS],
    input  board_pkg::key_in_t                    keys,
    input  logic                                  osd_pause,
    output logic [board_pkg::NUM_PLAYERS-1:0]     game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0]     game_start,
    output logic                                  game_pause,
    output logic                                  game_service,
    output logic                                  soft_rst,
    output logic [board_pkg::GFX_LAYERS-1:0]      gfx_en
);

    logic [board_pkg::NUM_PLAYERS-1:0] joy_coin;
    logic [board_pkg::NUM_PLAYERS-1:0] joy_start;
    logic                              joy_pause;
    logic                              key_pause_s, key_pause_l;
    logic                              joy_pause_s, joy_pause_l;
    logic                              osd_s, osd_l;
    logic                              key_reset_s, key_reset_l;
    logic [board_pkg::GFX_LAYERS-1:0]  key_gfx_s, key_gfx_l;
    logic                              pause_edge;

    always_comb begin
        for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
            joy_coin[p]  = joy_sync[p][board_pkg::COIN_BIT];
            joy_start[p] = joy_sync[p][board_pkg::START_BIT];
        end
    end

    // only players 1 and 2 carry a pause button
    assign joy_pause = joy_sync[0][board_pkg::PAUSE_BIT] | joy_sync[1][board_pkg::PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        game_coin  <= {board_pkg::NUM_PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}} ^
                      (joy_coin | keys.coin);
        game_start <= {board_pkg::NUM_PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}} ^
                      (joy_start | keys.start);
    end

    // samples and their previous values for edge detection
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            key_pause_s <= 1'b0;
            key_pause_l <= 1'b0;
            joy_pause_s <= 1'b0;
            joy_pause_l <= 1'b0;
            osd_s       <= 1'b0;
            osd_l       <= 1'b0;
            key_reset_s <= 1'b0;
            key_reset_l <= 1'b0;
            key_gfx_s   <= '0;
            key_gfx_l   <= '0;
        end else begin
            key_pause_s <= keys.pause;
            key_pause_l <= key_pause_s;
            joy_pause_s <= joy_pause;
            joy_pause_l <= joy_pause_s;
            osd_s       <= osd_pause;
            osd_l       <= osd_s;
            key_reset_s <= keys.reset;
            key_reset_l <= key_reset_s;
            key_gfx_s   <= keys.gfx;
            key_gfx_l   <= key_gfx_s;
        end
    end

    assign pause_edge = (key_pause_s & ~key_pause_l) | (joy_pause_s & ~joy_pause_l);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            game_service <= board_pkg::INPUTS_ACTIVE_LOW;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;     // all layers on
        end else begin
            soft_rst     <= key_reset_s & ~key_reset_l;
            gfx_en       <= gfx_en ^ (key_gfx_s & ~key_gfx_l);
            game_service <= keys.service ^ board_pkg::INPUTS_ACTIVE_LOW;
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_s != osd_l) begin
                game_pause <= osd_s;        // menu setting overrides toggles
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// File: design/board_pkg.sv
// input board package
// widths, bit positions, counts and the packed words that are
// shared by the joystick, key and reset logic of the board frame

package board_pkg;

    localparam int NUM_PLAYERS = 4;
    localparam int JOY_IN_W    = 16;     // board joystick word
    localparam int GAME_JOY_W  = 10;     // word seen by the game
    localparam int DIR_W       = 4;      // 0 right, 1 left, 2 down, 3 up
    localparam int BUTTONS     = 2;

    // start, coin and pause sit right above the game buttons
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    localparam int GFX_LAYERS   = 4;
    localparam int GAME_RST_LEN = 32;    // cycles held after the last cause
    localparam int RST_CNT_W    = $clog2(GAME_RST_LEN);

    localparam logic INPUTS_ACTIVE_LOW = 1'b1;

    typedef struct packed {
        logic [JOY_IN_W-DIR_W-1:0] upper;    // buttons, start, coin, pause
        logic [DIR_W-1:0]          dir;
    } board_joy_t;

    typedef struct packed {
        logic [GAME_JOY_W-DIR_W-1:0] buttons;
        logic [DIR_W-1:0]            dir;
    } game_joy_t;

    // decoded keyboard keys, all active high
    typedef struct packed {
        game_joy_t              joy1;
        game_joy_t              joy2;
        game_joy_t              joy3;
        logic [NUM_PLAYERS-1:0] start;
        logic [NUM_PLAYERS-1:0] coin;
        logic                   reset;
        logic                   pause;
        logic                   service;
        logic [GFX_LAYERS-1:0]  gfx;
    } key_in_t;

    // menu status word, high bits first
    typedef struct packed {
        logic [22:0] spare;
        logic        en4way;
        logic [1:0]  fxlevel;
        logic        enable_psg;
        logic        enable_fm;
        logic        dip_test;
        logic        osd_pause;
        logic        flip;
        logic        rot_control;
    } status_t;

endpackage

// File: design/game_reset_seq.sv
// game reset sequencer
// restarts on system reset, download, an external request, the
// keyboard reset key or a change of the flip setting, then keeps
// game_rst asserted for GAME_RST_LEN cycles after the last cause

module game_reset_seq (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic game_rst
);

    logic                            flip_q;
    logic                            flip_chg;
    logic                            cause;
    logic [board_pkg::RST_CNT_W-1:0] rst_cnt;

    always_ff @(posedge clk_sys) begin
        flip_q <= flip;                 // previous flip setting
    end

    assign flip_chg = flip ^ flip_q;
    assign cause    = rst | downloading | rst_req | soft_rst | flip_chg;

    // counter stops at GAME_RST_LEN-1, the release happens on the next edge
    always_ff @(posedge clk_sys) begin
        if (cause) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt < board_pkg::GAME_RST_LEN - 1) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

// File: design/input_board.sv
// input and reset board, top level
// four joystick paths, control keys, game reset sequencing and the
// registered copies of the menu settings used by the game

module input_board (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  board_pkg::board_joy_t             board_joy [board_pkg::NUM_PLAYERS],
    input  board_pkg::key_in_t                keys,
    input  board_pkg::status_t                status,
    input  logic                              downloading,
    input  logic                              rst_req,
    output board_pkg::game_joy_t              game_joy [board_pkg::NUM_PLAYERS],
    output logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    output logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    output logic                              game_service,
    output logic                              game_pause,
    output logic [board_pkg::GFX_LAYERS-1:0]  gfx_en,
    output logic                              game_rst,
    output logic                              enable_fm,
    output logic                              enable_psg,
    output logic                              dip_test,
    output logic [1:0]                        dip_fxlevel
);

    board_pkg::board_joy_t joy_sync [board_pkg::NUM_PLAYERS];
    board_pkg::game_joy_t  key_joy  [board_pkg::NUM_PLAYERS];
    logic                  soft_rst;

    // keyboard drives players 1 to 3 only
    always_comb begin
        key_joy    = '{default: '0};
        key_joy[0] = keys.joy1;
        key_joy[1] = keys.joy2;
        key_joy[2] = keys.joy3;
    end

    for (genvar p = 0; p < board_pkg::NUM_PLAYERS; p++) begin : g_player
        logic [board_pkg::DIR_W-1:0] dir_filt;

        joy_4way_filter u_filter (
            .clk_sys     ( clk_sys            ),
            .rst         ( rst                ),
            .enable      ( status.en4way      ),
            .dir_in      ( board_joy[p].dir   ),
            .dir_out     ( dir_filt           )
        );

        joy_player_map u_map (
            .clk_sys     ( clk_sys            ),
            .rst         ( rst                ),
            .board_in    ( board_joy[p]       ),
            .dir_filt    ( dir_filt           ),
            .key_joy     ( key_joy[p]         ),
            .rot_control ( status.rot_control ),
            .flip        ( ~status.flip       ),  // rotation uses the inverted setting
            .joy_sync    ( joy_sync[p]        ),
            .game_joy    ( game_joy[p]        )
        );
    end

    board_ctrl u_ctrl (
        .clk_sys      ( clk_sys          ),
        .rst          ( rst              ),
        .downloading  ( downloading      ),
        .joy_sync     ( joy_sync         ),
        .keys         ( keys             ),
        .osd_pause    ( status.osd_pause ),
        .game_coin    ( game_coin        ),
        .game_start   ( game_start       ),
        .game_pause   ( game_pause       ),
        .game_service ( game_service     ),
        .soft_rst     ( soft_rst         ),
        .gfx_en       ( gfx_en           )
    );

    game_reset_seq u_rst_seq (
        .clk_sys      ( clk_sys          ),
        .rst          ( rst              ),
        .downloading  ( downloading      ),
        .rst_req      ( rst_req          ),
        .soft_rst     ( soft_rst         ),
        .flip         ( status.flip      ),
        .game_rst     ( game_rst         )
    );

    always_ff @(posedge clk_sys) begin
        enable_fm   <= status.enable_fm;
        enable_psg  <= status.enable_psg;
        dip_test    <= status.dip_test;
        dip_fxlevel <= status.fxlevel;
    end

endmodule

// File: design/joy_4way_filter.sv
// 8-way to 4-way direction filter for one player
// the output register doubles as the synchroniser of the direction
// bits, and with the filter off it just samples the stick

module joy_4way_filter (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        enable,
    input  logic [board_pkg::DIR_W-1:0] dir_in,
    output logic [board_pkg::DIR_W-1:0] dir_out
);

    logic [board_pkg::DIR_W-1:0] dir_nxt;
    logic                        single_in;
    logic                        hold_prev;

    assign single_in = $onehot(dir_in);

    // a diagonal keeps the last accepted direction while it is still held
    assign hold_prev = $onehot(dir_out) && ((dir_in & dir_out) != '0);

    always_comb begin
        if (!enable) begin
            dir_nxt = dir_in;           // plain 8-way
        end else if (single_in) begin
            dir_nxt = dir_in;
        end else if (hold_prev) begin
            dir_nxt = dir_out;
        end else begin
            // released stick, or a diagonal entered fresh
            dir_nxt = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out <= '0;
        end else begin
            dir_out <= dir_nxt;
        end
    end

endmodule

// File: design/joy_player_map.sv
// joystick mapping for one player
// samples the board word, merges the keyboard joystick into it,
// remaps the directions for rotated screens and applies the
// polarity the game expects

module joy_player_map (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  board_pkg::board_joy_t       board_in,
    input  logic [board_pkg::DIR_W-1:0] dir_filt,
    input  board_pkg::game_joy_t        key_joy,
    input  logic                        rot_control,
    input  logic                        flip,
    output board_pkg::board_joy_t       joy_sync,
    output board_pkg::game_joy_t        game_joy
);

    logic [board_pkg::JOY_IN_W-board_pkg::DIR_W-1:0] upper_q;
    board_pkg::game_joy_t                            merged;
    board_pkg::game_joy_t                            rotated;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            upper_q <= '0;
        end else begin
            upper_q <= board_in.upper;
        end
    end

    // directions come already registered from the 4-way filter
    assign joy_sync = '{upper: upper_q, dir: dir_filt};

    assign merged = board_pkg::game_joy_t'(joy_sync[board_pkg::GAME_JOY_W-1:0] | key_joy);

    always_comb begin
        rotated = merged;
        if (rot_control) begin
            if (flip) begin
                // new 3..0 from old 1,0,2,3
                rotated.dir = {merged.dir[1], merged.dir[0], merged.dir[2], merged.dir[3]};
            end else begin
                // new 3..0 from old 2,3,0,1
                rotated.dir = {merged.dir[2], merged.dir[3], merged.dir[0], merged.dir[1]};
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // nothing pressed
            game_joy <= {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
        end else begin
            game_joy <= rotated ^ {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# builds the input board testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_board -f src.f -o tb_board
./obj_dir/tb_board > sim.log
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// File: sim/board_checker.sv
// input board checker
// cycle model of the joystick, key and reset rules that runs beside
// the DUT and compares every output on the falling clock edge

module board_checker (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  board_pkg::board_joy_t             board_joy [board_pkg::NUM_PLAYERS],
    input  board_pkg::key_in_t                keys,
    input  board_pkg::status_t                status,
    input  logic                              downloading,
    input  logic                              rst_req,
    input  board_pkg::game_joy_t              game_joy [board_pkg::NUM_PLAYERS],
    input  logic [board_pkg::NUM_PLAYERS-1:0] game_coin,
    input  logic [board_pkg::NUM_PLAYERS-1:0] game_start,
    input  logic                              game_service,
    input  logic                              game_pause,
    input  logic [board_pkg::GFX_LAYERS-1:0]  gfx_en,
    input  logic                              game_rst,
    input  logic                              enable_fm,
    input  logic                              enable_psg,
    input  logic                              dip_test,
    input  logic [1:0]                        dip_fxlevel,
    output int                                errors
);

    board_pkg::board_joy_t m_sync [board_pkg::NUM_PLAYERS];    // sampled board words
    board_pkg::game_joy_t  m_joy  [board_pkg::NUM_PLAYERS];
    logic [3:0] m_coin, m_start, m_gfx, gfx_now, gfx_last;
    logic       m_service, m_pause, m_soft, flip_last;
    logic [1:0] kp_hist, jp_hist, osd_hist, kr_hist;              // bit 0 is the newest sample
    logic [4:0] m_status;
    int         since_cause = 0;

    initial errors = 0;

    // 4-way rule: single direction passes, a diagonal keeps a held direction
    function automatic logic [3:0] filter_step(input logic en, input logic [3:0] din,
                                               input logic [3:0] last);
        if (!en || $countones(din) == 1) return din;
        if ($countones(last) == 1 && (din & last) != 4'h0) return last;
        return 4'h0;
    endfunction

    function automatic board_pkg::game_joy_t game_word(input board_pkg::board_joy_t sync,
                                                       input board_pkg::game_joy_t key,
                                                       input logic rot, input logic flip_inv);
        logic [9:0] w;
        logic [3:0] d;
        w = sync[9:0] | key;
        d = w[3:0];
        if (rot) begin
            // flipped: up from left, down from right, left from down, right from up
            w[3:0] = flip_inv ? {d[1], d[0], d[2], d[3]} : {d[2], d[3], d[0], d[1]};
        end
        return w ^ {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
    endfunction

    function automatic board_pkg::game_joy_t key_joy_for(input int p, input board_pkg::key_in_t k);
        if (p == 0) return k.joy1;
        if (p == 1) return k.joy2;
        if (p == 2) return k.joy3;
        return '0;                     // no keyboard player 4
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, got %h at time %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk_sys) begin : model
        logic cause;
        cause = rst | downloading | rst_req | m_soft | (status.flip != flip_last);
        flip_last   <= status.flip;
        since_cause <= cause ? 0 : (since_cause < board_pkg::GAME_RST_LEN) ?
                       since_cause + 1 : since_cause;
        m_status    <= {status.enable_fm, status.enable_psg, status.dip_test, status.fxlevel};
        for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
            m_coin[p]  <= board_pkg::INPUTS_ACTIVE_LOW ^
                          (m_sync[p][board_pkg::COIN_BIT] | keys.coin[p]);
            m_start[p] <= board_pkg::INPUTS_ACTIVE_LOW ^
                          (m_sync[p][board_pkg::START_BIT] | keys.start[p]);
        end
        if (rst) begin
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                m_sync[p] <= '0;
                m_joy[p]  <= {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
            end
            {kp_hist, jp_hist, osd_hist, kr_hist} <= '0;
            {gfx_now, gfx_last} <= '0;
            m_gfx     <= 4'hf;
            m_service <= board_pkg::INPUTS_ACTIVE_LOW;
            m_pause   <= 1'b0;
            m_soft    <= 1'b0;
        end else begin
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                m_sync[p].upper <= board_joy[p].upper;
                m_sync[p].dir   <= filter_step(status.en4way, board_joy[p].dir, m_sync[p].dir);
                m_joy[p] <= game_word(m_sync[p], key_joy_for(p, keys),
                                      status.rot_control, ~status.flip);
            end
            kp_hist  <= {kp_hist[0], keys.pause};
            jp_hist  <= {jp_hist[0], m_sync[0][board_pkg::PAUSE_BIT] |
                                     m_sync[1][board_pkg::PAUSE_BIT]};
            osd_hist <= {osd_hist[0], status.osd_pause};
            kr_hist  <= {kr_hist[0], keys.reset};
            gfx_now  <= keys.gfx;
            gfx_last <= gfx_now;
            m_soft   <= (kr_hist == 2'b01);
            m_gfx    <= m_gfx ^ (gfx_now & ~gfx_last);
            m_service <= board_pkg::INPUTS_ACTIVE_LOW ^ keys.service;
            if (downloading) m_pause <= 1'b0;
            else if (osd_hist[0] != osd_hist[1]) m_pause <= osd_hist[0];   // menu wins
            else if (kp_hist == 2'b01 || jp_hist == 2'b01) m_pause <= ~m_pause;
        end
    end

    always @(negedge clk_sys) begin
        if (!rst) begin
            for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
                compare($sformatf("game_joy[%0d]", p), 16'(m_joy[p]), 16'(game_joy[p]));
            end
            compare("game_coin", 16'(m_coin), 16'(game_coin));
            compare("game_start", 16'(m_start), 16'(game_start));
            compare("game_service", 16'(m_service), 16'(game_service));
            compare("game_pause", 16'(m_pause), 16'(game_pause));
            compare("gfx_en", 16'(m_gfx), 16'(gfx_en));
            compare("game_rst", 16'(since_cause < board_pkg::GAME_RST_LEN), 16'(game_rst));
            compare("status copies", 16'(m_status),
                    16'({enable_fm, enable_psg, dip_test, dip_fxlevel}));
        end
    end

endmodule

// File: sim/tb_board.sv
// input board testbench
// clock, reset and seeded random stimulus in phases, one for each
// group of board functions, with the checker comparing all outputs

module tb_board;

    logic                              clk_sys;
    logic                              rst;
    board_pkg::board_joy_t             board_joy [board_pkg::NUM_PLAYERS];
    board_pkg::key_in_t                keys;
    board_pkg::status_t                status;
    logic                              downloading;
    logic                              rst_req;
    board_pkg::game_joy_t              game_joy [board_pkg::NUM_PLAYERS];
    logic [board_pkg::NUM_PLAYERS-1:0] game_coin, game_start;
    logic                              game_service, game_pause, game_rst;
    logic [board_pkg::GFX_LAYERS-1:0]  gfx_en;
    logic                              enable_fm, enable_psg, dip_test;
    logic [1:0]                        dip_fxlevel;

    int    seed;
    int    tb_errors, chk_errors, err_mark;
    int    tests_run, tests_failed;
    string test_name;

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    input_board UUT (.*);

    board_checker u_check (.*, .errors(chk_errors));

    task automatic quiet_inputs();
        for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) board_joy[p] = '0;
        keys        = '0;
        status      = '0;
        downloading = 1'b0;
        rst_req     = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = tb_errors + chk_errors;
    endtask

    task automatic end_test();
        int n;
        n = tb_errors + chk_errors - err_mark;
        tests_run++;
        if (n == 0) begin
            $display("test %-24s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-24s failed with %0d errors", test_name, n);
        end
    endtask

    // one cycle of stimulus, mode picks the inputs that move
    task automatic drive_step(input int mode);
        logic [31:0] r;
        for (int p = 0; p < board_pkg::NUM_PLAYERS; p++) begin
            r = $random(seed);
            if (mode >= 2 && mode <= 4) board_joy[p] = r[15:0];
        end
        r = $random(seed);
        case (mode)
            2: begin
                {keys.joy3, keys.joy2, keys.joy1} = r[29:0];
                status.rot_control = r[30];
                status.en4way      = r[31];
                if (r[5:0] == 6'h0) status.flip = ~status.flip;     // rare
            end
            3: begin
                {keys.start, keys.coin} = r[7:0];
                keys.service            = r[8];
            end
            4: begin
                if (r[2:0] == 3'h0) keys.pause = ~keys.pause;
                if (r[7:4] == 4'h0) status.osd_pause = ~status.osd_pause;
                downloading = (r[12:9] == 4'h0);
            end
            5: begin
                rst_req     = (r[4:0] == 5'h0);
                downloading = (r[10:5] == 6'h0);
                // sparse enough that game_rst gets released between causes
                if (r[13:11] == 3'h0 && r[31:30] == 2'h0) keys.reset = ~keys.reset;
                if (r[19:14] == 6'h0) status.flip = ~status.flip;
                keys.gfx = r[23:20];
                {status.fxlevel, status.enable_psg, status.enable_fm, status.dip_test} = r[28:24];
            end
            default: ;
        endcase
    endtask

    task automatic run_cycles(input int mode, input int count);
        repeat (count) begin
            @(posedge clk_sys);
            #1;
            drive_step(mode);
        end
    endtask

    task automatic check_release();
        int n;
        n = 0;
        do begin
            @(posedge clk_sys);
            #1;
            n++;
        end while (game_rst && n < 4 * board_pkg::GAME_RST_LEN);
        if (game_rst) begin
            tb_errors++;
            $display("timeout: game_rst was never released after the system reset");
        end else if (n != board_pkg::GAME_RST_LEN) begin
            tb_errors++;
            $display("ERROR game_rst release cycle: expected %h, got %h",
                     board_pkg::GAME_RST_LEN, n);
        end
    endtask

    initial begin
        seed         = 32'hbbf44226;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        quiet_inputs();
        rst = 1'b1;
        repeat (8) @(posedge clk_sys);
        #1 rst = 1'b0;

        begin_test("reset values");
        check_release();
        end_test();
        begin_test("joystick path");
        run_cycles(2, 400);
        end_test();
        begin_test("coin and start");
        run_cycles(3, 300);
        end_test();
        begin_test("pause");
        run_cycles(4, 500);
        end_test();
        begin_test("game reset and gfx");
        run_cycles(5, 600);
        quiet_inputs();
        run_cycles(0, board_pkg::GAME_RST_LEN + 8);    // outputs settle, game_rst releases
        end_test();

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, tb_errors + chk_errors);
        if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
design/board_pkg.sv
design/game_reset_seq.sv
design/joy_4way_filter.sv
design/joy_player_map.sv
design/board_ctrl.sv
design/input_board.sv
sim/board_checker.sv
sim/tb_board.sv
